// File: mul_defines.svh
// Build-time sizing for the RV32 multiply unit
// Operand width and the depth of the array multiplier pipeline
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// ----------------------------------------
// Datapath width
// ----------------------------------------

// Operand and result width in bits
`define MUL_XLEN 32

// ----------------------------------------
// Pipeline depth
// ----------------------------------------

// Register stages inside the array multiplier
// MUL_XLEN has to divide evenly by this value
`define MUL_STAGES 4

`endif

// File: mul_types_pkg.sv
// Datapath types of the multiply unit
// Word types, the M-extension multiply operations and the request bundle
`default_nettype none

`include "mul_defines.svh"

package mul_types_pkg;

    // One operand or one result word
    typedef logic [`MUL_XLEN-1:0] word_t;

    // Full double-width product
    typedef logic [2*`MUL_XLEN-1:0] dword_t;

    // Encoded in funct3 order of the M extension
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_op_t;

    // Request as it arrives from the issue side
    // The multiplicand is rs1 and the multiplier is rs2
    typedef struct packed {
        mul_op_t op;
        word_t   multiplicand;
        word_t   multiplier;
    } mul_req_t;

endpackage

`default_nettype wire

// File: mul_ctrl_pkg.sv
// Control types of the multiply unit
// Controller FSM states and the side-band record carried beside each item
`default_nettype none

package mul_ctrl_pkg;

    // Busy status FSM
    // STALLED marks a cycle in which the output result was held back
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        ACTIVE  = 2'b01,
        STALLED = 2'b10
    } ctrl_state_t;

    // Travels one stage at a time next to the datapath
    // The negate flag tells the finalizer to flip the sign of the product
    typedef struct packed {
        logic                  valid;
        mul_types_pkg::mul_op_t op;
        logic                  negate;
    } mul_side_t;

endpackage

`default_nettype wire

// File: operand_conditioner.sv
// First pipeline stage of the multiply unit
// Turns signed operands into magnitudes and works out the sign of the product
`timescale 1ns/1ps
`default_nettype none

module operand_conditioner (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    stage_en_i,
    input  mul_types_pkg::mul_req_t req_i,
    output mul_types_pkg::word_t    mag_a_o,
    output mul_types_pkg::word_t    mag_b_o,
    output mul_ctrl_pkg::mul_side_t side_o
);

    import mul_types_pkg::*;
    import mul_ctrl_pkg::*;

    localparam int XLEN = $bits(word_t);

    logic  a_signed;
    logic  b_signed;
    logic  a_neg;
    logic  b_neg;
    word_t a_mag;
    word_t b_mag;

    // ----------------------------------------
    // Signedness per operation
    // ----------------------------------------

    // rs1 is signed for MUL, MULH and MULHSU
    assign a_signed = (req_i.op != MULHU);

    // rs2 is signed only for MUL and MULH
    assign b_signed = (req_i.op == MUL) || (req_i.op == MULH);

    // An operand only counts as negative when it is treated as signed
    assign a_neg = a_signed & req_i.multiplicand[XLEN-1];
    assign b_neg = b_signed & req_i.multiplier[XLEN-1];

    // Two's complement gives the magnitude
    // The most negative value maps onto itself, which is correct read unsigned
    assign a_mag = a_neg ? (~req_i.multiplicand + 1'b1) : req_i.multiplicand;
    assign b_mag = b_neg ? (~req_i.multiplier + 1'b1) : req_i.multiplier;

    // ----------------------------------------
    // Side-band towards the controller
    // ----------------------------------------

    // The product is negative when exactly one negative signed operand is present
    // For MUL the low word comes out the same either way
    // The valid bit is left clear here, the controller inserts the accept strobe
    assign side_o = '{valid: 1'b0, op: req_i.op, negate: a_neg ^ b_neg};

    // Stage 1 register, frozen while the pipeline is stalled
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mag_a_o <= '0;
            mag_b_o <= '0;
        end else if (stage_en_i) begin
            mag_a_o <= a_mag;
            mag_b_o <= b_mag;
        end
    end

endmodule

`default_nettype wire

// File: pipelined_array_multiplier.sv
// Unsigned pipelined array multiplier
// Partial-product rows are summed a slice at a time over STAGES registers
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module pipelined_array_multiplier #(
    parameter int DATA_WIDTH = `MUL_XLEN,
    parameter int STAGES     = `MUL_STAGES
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stage_en_i,
    input  mul_types_pkg::word_t  multiplicand_i,
    input  mul_types_pkg::word_t  multiplier_i,
    output mul_types_pkg::dword_t product_o
);

    // Multiplier bits consumed per stage
    // DATA_WIDTH has to be a multiple of STAGES
    localparam int ROWS = DATA_WIDTH / STAGES;

    // ----------------------------------------
    // Stage chain
    // ----------------------------------------

    // Stage s handles multiplier bits s*ROWS up to s*ROWS+ROWS-1
    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        logic [DATA_WIDTH-1:0]   mcand_in;
        logic [DATA_WIDTH-1:0]   mplier_in;
        logic [2*DATA_WIDTH-1:0] acc_in;
        logic [2*DATA_WIDTH-1:0] acc_sum;
        logic [2*DATA_WIDTH-1:0] acc_q;

        if (s == 0) begin : g_head
            // First stage starts from an empty running sum
            assign mcand_in  = multiplicand_i;
            assign mplier_in = multiplier_i;
            assign acc_in    = '0;
        end else begin : g_tail
            assign mcand_in  = g_stage[s-1].g_fwd.mcand_q;
            assign mplier_in = g_stage[s-1].g_fwd.mplier_q;
            assign acc_in    = g_stage[s-1].acc_q;
        end

        // Add this stage's rows, each one the multiplicand shifted to its bit weight
        always_comb begin
            acc_sum = acc_in;
            for (int r = 0; r < ROWS; r++) begin
                if (mplier_in[s*ROWS + r]) begin
                    acc_sum = acc_sum + ({{DATA_WIDTH{1'b0}}, mcand_in} << (s*ROWS + r));
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                acc_q <= '0;
            end else if (stage_en_i) begin
                acc_q <= acc_sum;
            end
        end

        // Operands move along with the sum, except past the final stage
        if (s < STAGES - 1) begin : g_fwd
            logic [DATA_WIDTH-1:0] mcand_q;
            logic [DATA_WIDTH-1:0] mplier_q;

            always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                    mcand_q  <= '0;
                    mplier_q <= '0;
                end else if (stage_en_i) begin
                    mcand_q  <= mcand_in;
                    mplier_q <= mplier_in;
                end
            end
        end
    end

    // Every row has been added once the last stage has registered
    assign product_o = g_stage[STAGES-1].acc_q;

endmodule

`default_nettype wire

// File: product_finalizer.sv
// Last pipeline stage of the multiply unit
// Restores the sign of the product and picks the low or the high word
`timescale 1ns/1ps
`default_nettype none

module product_finalizer (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    stage_en_i,
    input  mul_types_pkg::dword_t   product_i,
    input  mul_ctrl_pkg::mul_side_t side_i,
    output mul_types_pkg::word_t    result_o
);

    import mul_types_pkg::*;
    import mul_ctrl_pkg::*;

    localparam int XLEN = $bits(word_t);

    dword_t signed_prod;
    word_t  result_d;

    // Negate over the full double width so the high word carries the borrow
    assign signed_prod = side_i.negate ? (~product_i + 1'b1) : product_i;

    // MUL keeps the low half, every MULH variant keeps the high half
    assign result_d = (side_i.op == MUL) ? signed_prod[XLEN-1:0]
                                         : signed_prod[2*XLEN-1:XLEN];

    // ----------------------------------------
    // Output register
    // ----------------------------------------

    // Bubbles leave the previous result in place
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_o <= '0;
        end else if (stage_en_i && side_i.valid) begin
            result_o <= result_d;
        end
    end

endmodule

`default_nettype wire

// File: mul_controller.sv
// Control for the multiply pipeline
// Valid and side-band chain, global stall, in-flight count and busy status
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_controller (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    accept_i,
    input  mul_ctrl_pkg::mul_side_t side_i,
    input  logic                    resp_ready_i,
    output logic                    stage_en_o,
    output logic                    req_ready_o,
    output mul_ctrl_pkg::mul_side_t out_side_o,
    output logic                    resp_valid_o,
    output logic                    busy_o
);

    import mul_ctrl_pkg::*;

    // Conditioner, multiplier stages and the output register
    localparam int DEPTH = `MUL_STAGES + 2;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mul_side_t [DEPTH-1:0] chain_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [CNT_W-1:0]      cnt_d;
    logic                  consume;
    ctrl_state_t           state_q;
    ctrl_state_t           state_d;

    // ----------------------------------------
    // Valid chain and stall
    // ----------------------------------------

    assign resp_valid_o = chain_q[DEPTH-1].valid;
    assign consume      = resp_valid_o && resp_ready_i;

    // Everything freezes while a finished result waits on the consumer
    assign stage_en_o  = !(resp_valid_o && !resp_ready_i);
    assign req_ready_o = stage_en_o;

    // Entry DEPTH-2 lines up with the multiplier output feeding the finalizer
    assign out_side_o = chain_q[DEPTH-2];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            chain_q <= '0;
        end else if (stage_en_o) begin
            chain_q[0] <= '{valid: accept_i, op: side_i.op, negate: side_i.negate};
            for (int i = 1; i < DEPTH; i++) begin
                chain_q[i] <= chain_q[i-1];
            end
        end
    end

    // ----------------------------------------
    // In-flight count and busy FSM
    // ----------------------------------------

    // Items count from acceptance until the consumer takes them
    always_comb begin
        cnt_d = cnt_q;
        if (accept_i && !consume) begin
            cnt_d = cnt_q + CNT_W'(1);
        end else if (consume && !accept_i) begin
            cnt_d = cnt_q - CNT_W'(1);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept_i) begin
                    state_d = ACTIVE;
                end
            end
            ACTIVE: begin
                if (cnt_d == '0) begin
                    state_d = IDLE;
                end else if (!stage_en_o) begin
                    state_d = STALLED;
                end
            end
            STALLED: begin
                // Leaves once the held result is taken
                if (stage_en_o) begin
                    state_d = (cnt_d == '0) ? IDLE : ACTIVE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q   <= '0;
            state_q <= IDLE;
        end else begin
            cnt_q   <= cnt_d;
            state_q <= state_d;
        end
    end

    assign busy_o = (state_q != IDLE);

endmodule

`default_nettype wire

// File: mul_unit_top.sv
// Pipelined integer multiply unit for an RV32 core
// MUL, MULH, MULHSU and MULHU with one new request per cycle
`timescale 1ns/1ps
`default_nettype none

module mul_unit_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    req_valid_i,
    input  mul_types_pkg::mul_req_t req_i,
    output logic                    req_ready_o,
    input  logic                    resp_ready_i,
    output logic                    resp_valid_o,
    output mul_types_pkg::word_t    resp_o,
    output logic                    busy_o
);

    import mul_types_pkg::*;
    import mul_ctrl_pkg::*;

    logic      accept;
    logic      stage_en;
    word_t     mag_a;
    word_t     mag_b;
    dword_t    product;
    mul_side_t cond_side;
    mul_side_t fin_side;

    // Handshake on the request side
    assign accept = req_valid_i && req_ready_o;

    // ----------------------------------------
    // Control
    // ----------------------------------------

    mul_controller u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .accept_i     (accept),
        .side_i       (cond_side),
        .resp_ready_i (resp_ready_i),
        .stage_en_o   (stage_en),
        .req_ready_o  (req_ready_o),
        .out_side_o   (fin_side),
        .resp_valid_o (resp_valid_o),
        .busy_o       (busy_o)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    operand_conditioner u_cond (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stage_en_i (stage_en),
        .req_i      (req_i),
        .mag_a_o    (mag_a),
        .mag_b_o    (mag_b),
        .side_o     (cond_side)
    );

    pipelined_array_multiplier u_mult (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .stage_en_i     (stage_en),
        .multiplicand_i (mag_a),
        .multiplier_i   (mag_b),
        .product_o      (product)
    );

    product_finalizer u_fin (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stage_en_i (stage_en),
        .product_i  (product),
        .side_i     (fin_side),
        .result_o   (resp_o)
    );

endmodule

`default_nettype wire

// File: tb_mul_vectors.svh
// Directed vectors for the multiply unit testbench
// Corner cases for all four operations, with a few cycles of back-pressure
`ifndef TB_MUL_VECTORS_SVH
`define TB_MUL_VECTORS_SVH

// Each row lists the op, both operands, the expected result and resp_ready_i for the issue cycle
localparam int NUM_VECTORS = 16;

vector_t vectors [NUM_VECTORS];

task automatic load_vectors();
    vectors[0]  = '{MUL,    32'h0000_0003, 32'h0000_0005, 32'h0000_000F, 1'b1};
    // Minus one squared
    vectors[1]  = '{MUL,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001, 1'b1};
    vectors[2]  = '{MULH,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1};
    vectors[3]  = '{MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 1'b1};
    // Most negative value times itself
    vectors[4]  = '{MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 1'b1};
    vectors[5]  = '{MUL,    32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 1'b0};
    vectors[6]  = '{MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000, 1'b0};
    vectors[7]  = '{MULHU,  32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 1'b1};
    vectors[8]  = '{MULH,   32'h0000_0000, 32'hDEAD_BEEF, 32'h0000_0000, 1'b1};
    vectors[9]  = '{MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1};
    // Mixed signs, seven times minus three
    vectors[10] = '{MUL,    32'h0000_0007, 32'hFFFF_FFFD, 32'hFFFF_FFEB, 1'b0};
    vectors[11] = '{MULH,   32'h0000_0007, 32'hFFFF_FFFD, 32'hFFFF_FFFF, 1'b1};
    vectors[12] = '{MULHSU, 32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFF, 1'b1};
    vectors[13] = '{MULHU,  32'hFFFF_FFFF, 32'h0000_0002, 32'h0000_0001, 1'b1};
    vectors[14] = '{MULH,   32'h7FFF_FFFF, 32'h8000_0000, 32'hC000_0000, 1'b0};
    vectors[15] = '{MUL,    32'h7FFF_FFFF, 32'h8000_0000, 32'h8000_0000, 1'b1};
endtask

`endif

// File: tb_mul_unit.sv
// Testbench for the pipelined multiply unit
// Directed table, random phase with back-pressure, queue scoreboard and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module tb_mul_unit;

    import mul_types_pkg::*;

    localparam int XLEN         = `MUL_XLEN;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 200;
    localparam int RNG_SEED     = 75;
    // Edges from acceptance to consumption when nothing stalls
    localparam int LATENCY      = `MUL_STAGES + 2;

    typedef struct packed {
        mul_op_t op;
        word_t   a;
        word_t   b;
        word_t   expected;
        logic    ready;
    } vector_t;

    // One accepted item waiting for its result
    typedef struct packed {
        word_t       expected;
        logic [31:0] accept_cycle;
        logic [31:0] accept_stalls;
    } pending_t;

    `include "tb_mul_vectors.svh"

    localparam int TIMEOUT_CYCLES = 20 * (NUM_VECTORS + NUM_RANDOM) + 100;

    logic        clk_i;
    logic        rst_n_i;
    logic        req_valid_i;
    mul_req_t    req_i;
    logic        req_ready_o;
    logic        resp_ready_i;
    logic        resp_valid_o;
    word_t       resp_o;
    logic        busy_o;

    // Expected result of the request currently on req_i
    word_t       cur_expected;
    pending_t    exp_q [$];
    logic [31:0] cycle_cnt = '0;
    logic [31:0] stall_cnt = '0;
    logic        held      = 1'b0;
    word_t       held_resp = '0;

    mul_unit_top dut0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .resp_ready_i (resp_ready_i),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .busy_o       (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Error reporting and reference model
    // ----------------------------------------

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("Fail %s expected 0x%08h actual 0x%08h", name, expected, actual);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic protocol_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    // rs1 is signed except for MULHU, rs2 only for MUL and MULH
    function automatic word_t reference_result(input mul_op_t op, input word_t a,
                                               input word_t b);
        dword_t wide_a;
        dword_t wide_b;
        dword_t full;
        wide_a = (op != MULHU) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        wide_b = (op == MUL || op == MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        // Truncating to two words is exact modulo 2**(2*XLEN)
        full = wide_a * wide_b;
        return (op == MUL) ? full[XLEN-1:0] : full[2*XLEN-1:XLEN];
    endfunction

    // Roughly four in ten operands are corner values
    function automatic word_t pick_operand();
        case ($urandom_range(11, 0))
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'hFFFF_FFFF;
            3: return 32'h8000_0000;
            4: return 32'h7FFF_FFFF;
            default: return $urandom();
        endcase
    endfunction

    function automatic logic draw_ready();
        return ($urandom_range(3, 0) != 0);
    endfunction

    // Presents one request and returns right after its handshake edge
    task automatic issue_item(input mul_op_t op, input word_t a, input word_t b,
                              input word_t expected, input logic ready_first,
                              input logic random_ready);
        req_valid_i  <= 1'b1;
        req_i        <= '{op: op, multiplicand: a, multiplier: b};
        cur_expected <= expected;
        resp_ready_i <= ready_first;
        @(posedge clk_i);
        while (!req_ready_o) begin
            resp_ready_i <= random_ready ? draw_ready() : 1'b1;
            @(posedge clk_i);
        end
    endtask

    // ----------------------------------------
    // Scoreboard
    // ----------------------------------------

    // Reads the values that the DUT itself sees at this edge
    always @(posedge clk_i) begin : scoreboard
        pending_t    entry;
        logic        stall;
        logic [31:0] latency;
        if (rst_n_i) begin
            stall = resp_valid_o && !resp_ready_i;
            // Busy tracks the number of accepted but unconsumed items
            assert (busy_o == (exp_q.size() != 0))
                else value_mismatch("busy_o", 32'(exp_q.size() != 0), 32'(busy_o));
            assert (req_ready_o == !stall)
                else value_mismatch("req_ready_o", 32'(!stall), 32'(req_ready_o));
            // A result held back on the previous edge must still be there unchanged
            if (held) begin
                assert (resp_valid_o)
                    else protocol_error("resp_valid_o dropped before the result was taken");
                assert (resp_o == held_resp)
                    else value_mismatch("resp_o", held_resp, resp_o);
            end
            if (resp_valid_o && resp_ready_i) begin
                assert (exp_q.size() != 0)
                    else protocol_error("a result came out with nothing in flight");
                entry   = exp_q.pop_front();
                // Every stalled edge in between adds one cycle
                latency = cycle_cnt - entry.accept_cycle - (stall_cnt - entry.accept_stalls);
                assert (resp_o == entry.expected)
                    else value_mismatch("resp_o", entry.expected, resp_o);
                assert (latency == LATENCY)
                    else value_mismatch("resp_valid_o latency", 32'(LATENCY), latency);
            end
            if (req_valid_i && req_ready_o) begin
                entry.expected      = cur_expected;
                entry.accept_cycle  = cycle_cnt;
                entry.accept_stalls = stall_cnt;
                exp_q.push_back(entry);
            end
            if (stall) begin
                stall_cnt = stall_cnt + 32'd1;
            end
            held      = stall;
            held_resp = resp_o;
            cycle_cnt = cycle_cnt + 32'd1;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(negedge clk_i);
            cycles++;
            assert (cycles < TIMEOUT_CYCLES)
                else protocol_error("timeout, the results did not all come back in time");
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin : stimulus
        mul_op_t op;
        word_t   a;
        word_t   b;
        void'($urandom(RNG_SEED));
        rst_n_i      <= 1'b0;
        req_valid_i  <= 1'b0;
        req_i        <= '0;
        resp_ready_i <= 1'b0;
        cur_expected <= '0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i      <= 1'b1;
        resp_ready_i <= 1'b1;

        // Idle outputs straight out of reset
        @(negedge clk_i);
        assert (!resp_valid_o) else value_mismatch("resp_valid_o", 32'h0, 32'(resp_valid_o));
        assert (!busy_o) else value_mismatch("busy_o", 32'h0, 32'(busy_o));
        assert (req_ready_o) else value_mismatch("req_ready_o", 32'h1, 32'(req_ready_o));
        @(posedge clk_i);

        // Directed rows back to back, each row's ready bit only for its first cycle
        for (int i = 0; i < NUM_VECTORS; i++) begin
            assert (reference_result(vectors[i].op, vectors[i].a, vectors[i].b)
                    == vectors[i].expected)
                else protocol_error($sformatf("vector %0d disagrees with the reference model", i));
            issue_item(vectors[i].op, vectors[i].a, vectors[i].b, vectors[i].expected,
                       vectors[i].ready, 1'b0);
        end

        // Random operations with idle gaps and random back-pressure
        for (int n = 0; n < NUM_RANDOM; n++) begin
            while ($urandom_range(3, 0) == 0) begin
                req_valid_i  <= 1'b0;
                resp_ready_i <= draw_ready();
                @(posedge clk_i);
            end
            op = mul_op_t'(2'($urandom_range(3, 0)));
            a  = pick_operand();
            b  = pick_operand();
            issue_item(op, a, b, reference_result(op, a, b), draw_ready(), 1'b1);
        end

        // Drain everything still in flight
        req_valid_i  <= 1'b0;
        resp_ready_i <= 1'b1;
        do begin
            @(negedge clk_i);
        end while (exp_q.size() != 0);
        assert (!busy_o) else value_mismatch("busy_o", 32'h0, 32'(busy_o));
        assert (!resp_valid_o) else value_mismatch("resp_valid_o", 32'h0, 32'(resp_valid_o));
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
mul_types_pkg.sv
mul_ctrl_pkg.sv
operand_conditioner.sv
pipelined_array_multiplier.sv
product_finalizer.sv
mul_controller.sv
mul_unit_top.sv
tb_mul_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the multiply unit testbench with Verilator and runs it.
# The exit status of the simulation is the test result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f build.f \
    --top-module tb_mul_unit \
    -Mdir obj_dir \
    -o sim_mul_unit

./obj_dir/sim_mul_unit
